/* gem_consts.svh */
`ifndef GEM_CONSTS_SVH
`define GEM_CONSTS_SVH

// ------------------------------
// link side
// ------------------------------

// fibers 0,1 from chamber a and 2,3 from chamber b
`define GEM_NUM_FIBERS 4

// frame separator k-codes in rotation order
`define GEM_KC_BC 8'hBC
`define GEM_KC_F7 8'hF7
`define GEM_KC_FB 8'hFB
`define GEM_KC_FD 8'hFD

// ------------------------------
// bunch crossing timing
// ------------------------------

`define GEM_ORBIT_LEN 3564   // bunch crossings per lhc orbit
`define GEM_BC0_OFFSET 8     // bx where a chamber bc0 marker should land
`define GEM_BX_W 12          // enough for one orbit

// ------------------------------
// readout
// ------------------------------

`define GEM_EVT_CREDITS 4    // free slots downstream after reset

`endif

/* gem_link_pkg.sv */
`include "gem_consts.svh"

package gem_link_pkg;

  // separator k-codes as sent on each fiber
  typedef enum logic [7:0] {
    SEP_BC = `GEM_KC_BC,
    SEP_F7 = `GEM_KC_F7,
    SEP_FB = `GEM_KC_FB,
    SEP_FD = `GEM_KC_FD
  } sep_code_t;

  // per fiber check state
  typedef enum logic {
    CHK_IDLE,   // waiting for first valid separator
    CHK_TRACK   // rotation locked, errors counted
  } fiber_chk_t;

  // true for one of the four separators
  function automatic logic sep_in_table(logic [7:0] k);
    return (k == SEP_BC) || (k == SEP_F7) || (k == SEP_FB) || (k == SEP_FD);
  endfunction

  // next separator in the rotation
  function automatic sep_code_t sep_rotate(sep_code_t s);
    case (s)
      SEP_BC:  return SEP_F7;
      SEP_F7:  return SEP_FB;
      SEP_FB:  return SEP_FD;
      default: return SEP_BC;   // fd wraps back to bc
    endcase
  endfunction

endpackage

/* gem_event_pkg.sv */
package gem_event_pkg;

  // event opcodes on the readout port
  typedef enum logic [2:0] {
    EVT_LOST_A = 3'd1,   // chamber a fibers disagree
    EVT_LOST_B = 3'd2,   // chamber b fibers disagree
    EVT_LOST_S = 3'd3,   // chambers disagree with each other
    EVT_BC0_A  = 3'd4,   // chamber a bc0 marker off its bx
    EVT_BC0_B  = 3'd5    // chamber b bc0 marker off its bx
  } evt_op_t;

  // round robin pointer of the readout arbiter
  typedef enum logic {
    ARB_LAST_MON,   // sync monitor won last
    ARB_LAST_BC0    // bc0 checker won last
  } arb_state_t;

endpackage

/* gem_sync_mon.sv */
`timescale 1ns/100ps
`include "gem_consts.svh"

module gem_sync_mon (
  input  logic                         clock,
  input  logic                         arst_n,
  input  logic                         ttc_resync,      // sync clear
  input  logic [7:0]                   kchar0,
  input  logic [7:0]                   kchar1,
  input  logic [7:0]                   kchar2,
  input  logic [7:0]                   kchar3,
  input  logic [`GEM_NUM_FIBERS-1:0]   fiber_enable,
  input  logic [`GEM_NUM_FIBERS-1:0]   link_good,
  input  logic                         overflow_a,
  input  logic                         overflow_b,
  input  logic                         bc0marker_a,
  input  logic                         bc0marker_b,
  input  logic                         resyncmarker_a,
  input  logic                         resyncmarker_b,
  input  logic                         gnt,
  output logic                         synced_a,
  output logic                         synced_b,
  output logic                         synced_s,
  output logic                         lostsync_a,
  output logic                         lostsync_b,
  output logic                         lostsync_s,
  output logic                         req,
  output gem_event_pkg::evt_op_t       op
);
  import gem_link_pkg::*;
  import gem_event_pkg::*;

  localparam int NF = `GEM_NUM_FIBERS;

  logic [7:0]    kchar [NF];
  logic [1:0]    marker;         // overflow, bc0 or resync per chamber
  logic [1:0]    skip;           // chamber check bypassed this cycle
  logic [NF-1:0] sep_err;        // registered rotation error per fiber
  logic          sync_a, sync_b, sync_s;
  logic [2:0]    lost_d;         // lostsync one cycle back
  logic [2:0]    rise;           // latch just set
  logic [2:0]    pend;           // sticky events {s, b, a}
  logic [2:0]    pend_next;
  logic [2:0]    pend_left;      // pending after this cycle's grant
  logic [2:0]    sel;            // one-hot event on offer

  assign kchar[0] = kchar0;
  assign kchar[1] = kchar1;
  assign kchar[2] = kchar2;
  assign kchar[3] = kchar3;

  assign marker[0] = overflow_a | bc0marker_a | resyncmarker_a;
  assign marker[1] = overflow_b | bc0marker_b | resyncmarker_b;

  // ------------------------------
  // separator rotation per fiber
  // ------------------------------
  for (genvar f = 0; f < NF; f++) begin : g_fiber
    logic       in_table;
    sep_code_t  sep_cur;   // value that drives the rotation
    sep_code_t  exp_q;     // expected separator this cycle
    fiber_chk_t chk_q;
    logic       err_q;

    assign in_table = sep_in_table(kchar[f]);
    // markers and junk codes keep the expected value so one bad frame stays one error
    assign sep_cur  = (marker[f/2] || !in_table) ? exp_q : sep_code_t'(kchar[f]);
    assign sep_err[f] = err_q;

    always_ff @(posedge clock or negedge arst_n) begin
      if (!arst_n) begin
        chk_q <= CHK_IDLE;
        exp_q <= SEP_BC;
        err_q <= 1'b0;
      end else if (ttc_resync) begin
        chk_q <= CHK_IDLE;
        exp_q <= SEP_BC;
        err_q <= 1'b0;
      end else if (chk_q == CHK_IDLE) begin
        err_q <= 1'b0;
        if (!marker[f/2] && in_table) begin   // first real separator locks
          chk_q <= CHK_TRACK;
          exp_q <= sep_rotate(sep_code_t'(kchar[f]));
        end
      end else begin
        err_q <= !marker[f/2] && (!in_table || (sep_cur != exp_q));
        exp_q <= sep_rotate(sep_cur);
      end
    end
  end

  // ------------------------------
  // chamber and super-chamber sync
  // ------------------------------
  assign skip[0] = marker[0] | ~&link_good[1:0] | ~&fiber_enable[1:0];
  assign skip[1] = marker[1] | ~&link_good[3:2] | ~&fiber_enable[3:2];

  assign sync_a = skip[0] | (~|sep_err[1:0] & (kchar0 == kchar1));
  assign sync_b = skip[1] | (~|sep_err[3:2] & (kchar2 == kchar3));
  assign sync_s = ((kchar0 == kchar2) & sync_a & sync_b) | (|skip);

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      {synced_s, synced_b, synced_a}       <= 3'b111;
      {lostsync_s, lostsync_b, lostsync_a} <= 3'b000;
      lost_d                               <= 3'b000;
    end else if (ttc_resync) begin
      {synced_s, synced_b, synced_a}       <= 3'b111;
      {lostsync_s, lostsync_b, lostsync_a} <= 3'b000;
      lost_d                               <= 3'b000;
    end else begin
      synced_a   <= sync_a;
      synced_b   <= sync_b;
      synced_s   <= sync_s;
      lostsync_a <= lostsync_a | ~sync_a;   // sticky until resync
      lostsync_b <= lostsync_b | ~sync_b;
      lostsync_s <= lostsync_s | ~sync_s;
      lost_d     <= {lostsync_s, lostsync_b, lostsync_a};
    end
  end

  // ------------------------------
  // event requests
  // ------------------------------
  assign rise      = {lostsync_s, lostsync_b, lostsync_a} & ~lost_d;
  assign pend_next = pend | rise;
  assign pend_left = pend_next & ~(gnt ? sel : 3'b000);

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      pend <= 3'b000;
      sel  <= 3'b000;
    end else if (ttc_resync) begin
      pend <= 3'b000;
      sel  <= 3'b000;
    end else begin
      pend <= pend_left;
      if (gnt || (sel == 3'b000))
        sel <= pend_left & (~pend_left + 3'd1);   // lowest bit first so a, b, s
    end
  end

  assign req = |sel;
  assign op  = sel[0] ? EVT_LOST_A : (sel[1] ? EVT_LOST_B : EVT_LOST_S);

endmodule

/* gem_bc0_check.sv */
`timescale 1ns/100ps
`include "gem_consts.svh"

module gem_bc0_check (
  input  logic                    clock,
  input  logic                    arst_n,
  input  logic                    ttc_resync,   // clears pending and latches
  input  logic                    ttc_bc0,      // orbit start pulse
  input  logic                    bc0marker_a,
  input  logic                    bc0marker_b,
  input  logic                    gnt,
  output logic [`GEM_BX_W-1:0]    bx_count,
  output logic                    req,
  output gem_event_pkg::evt_op_t  op
);
  import gem_event_pkg::*;

  localparam logic [`GEM_BX_W-1:0] BX_LAST = `GEM_BX_W'(`GEM_ORBIT_LEN - 1);
  localparam logic [`GEM_BX_W-1:0] BX_BC0  = `GEM_BX_W'(`GEM_BC0_OFFSET);

  logic [1:0] misalign;    // {b, a} marker off the expected bx
  logic [1:0] bad;         // misalignment seen since reset
  logic [1:0] fire;        // first misalignment per chamber
  logic [1:0] pend;
  logic [1:0] pend_next;
  logic [1:0] pend_left;
  logic [1:0] sel;         // one-hot chamber on offer

  // ------------------------------
  // bunch crossing counter
  // ------------------------------
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n)
      bx_count <= '0;
    else if (ttc_bc0)
      bx_count <= '0;                  // realign on orbit start
    else if (bx_count == BX_LAST)
      bx_count <= '0;                  // wrap at end of orbit
    else
      bx_count <= bx_count + 1'b1;
  end

  // ------------------------------
  // marker alignment
  // ------------------------------
  assign misalign = {bc0marker_b, bc0marker_a} & {2{bx_count != BX_BC0}};
  assign fire     = misalign & ~bad;   // one event per chamber per resync

  assign pend_next = pend | fire;
  assign pend_left = pend_next & ~(gnt ? sel : 2'b00);

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      bad  <= 2'b00;
      pend <= 2'b00;
      sel  <= 2'b00;
    end else if (ttc_resync) begin
      bad  <= 2'b00;
      pend <= 2'b00;
      sel  <= 2'b00;
    end else begin
      bad  <= bad | misalign;
      pend <= pend_left;
      // offer a new chamber when idle or just granted, a before b
      if (gnt || (sel == 2'b00))
        sel <= pend_left[0] ? 2'b01 : {pend_left[1], 1'b0};
    end
  end

  assign req = |sel;
  assign op  = sel[0] ? EVT_BC0_A : EVT_BC0_B;

endmodule

/* gem_event_arb.sv */
`timescale 1ns/100ps
`include "gem_consts.svh"

module gem_event_arb (
  input  logic                    clock,
  input  logic                    arst_n,
  input  logic                    mon_req,
  input  gem_event_pkg::evt_op_t  mon_op,
  input  logic                    bc0_req,
  input  gem_event_pkg::evt_op_t  bc0_op,
  input  logic [`GEM_BX_W-1:0]    bx_count,
  input  logic                    credit_return,   // one slot freed downstream
  output logic                    mon_gnt,
  output logic                    bc0_gnt,
  output logic                    evt_valid,
  output gem_event_pkg::evt_op_t  evt_op,
  output logic [`GEM_BX_W-1:0]    evt_bx
);
  import gem_event_pkg::*;

  localparam int            CW       = $clog2(`GEM_EVT_CREDITS + 1);
  localparam logic [CW-1:0] CRED_MAX = CW'(`GEM_EVT_CREDITS);

  logic [CW-1:0] credit_cnt;    // free readout slots
  logic          have_credit;
  logic          any_gnt;
  arb_state_t    last_q;        // round robin pointer

  // ------------------------------
  // grant, combinational
  // ------------------------------
  assign have_credit = (credit_cnt != '0);

  // on a tie the side that did not win last goes first
  assign mon_gnt = have_credit & mon_req & (~bc0_req | (last_q == ARB_LAST_BC0));
  assign bc0_gnt = have_credit & bc0_req & (~mon_req | (last_q == ARB_LAST_MON));
  assign any_gnt = mon_gnt | bc0_gnt;

  // ------------------------------
  // credits and pointer
  // ------------------------------
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      credit_cnt <= CRED_MAX;
      last_q     <= ARB_LAST_BC0;      // monitor wins the first tie
    end else begin
      if (any_gnt && !credit_return)
        credit_cnt <= credit_cnt - 1'b1;
      else if (!any_gnt && credit_return && (credit_cnt != CRED_MAX))
        credit_cnt <= credit_cnt + 1'b1;
      // grant and return together leave the count alone

      if (mon_gnt)
        last_q <= ARB_LAST_MON;
      else if (bc0_gnt)
        last_q <= ARB_LAST_BC0;
    end
  end

  // ------------------------------
  // readout word
  // ------------------------------
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n)
      evt_valid <= 1'b0;
    else
      evt_valid <= any_gnt;            // one cycle after the grant
  end

  always_ff @(posedge clock) begin
    if (any_gnt) begin
      evt_op <= mon_gnt ? mon_op : bc0_op;
      evt_bx <= bx_count;              // bx stamped at the grant
    end
  end

endmodule

/* gem_sync_top.sv */
`timescale 1ns/100ps
`include "gem_consts.svh"

module gem_sync_top (
  input  logic                         clock,
  input  logic                         arst_n,
  input  logic [7:0]                   kchar0,
  input  logic [7:0]                   kchar1,
  input  logic [7:0]                   kchar2,
  input  logic [7:0]                   kchar3,
  input  logic [`GEM_NUM_FIBERS-1:0]   fiber_enable,
  input  logic [`GEM_NUM_FIBERS-1:0]   link_good,
  input  logic                         overflow_a,
  input  logic                         overflow_b,
  input  logic                         bc0marker_a,
  input  logic                         bc0marker_b,
  input  logic                         resyncmarker_a,
  input  logic                         resyncmarker_b,
  input  logic                         ttc_bc0,
  input  logic                         ttc_resync,
  input  logic                         credit_return,
  output logic                         synced_a,
  output logic                         synced_b,
  output logic                         synced_s,
  output logic                         lostsync_a,
  output logic                         lostsync_b,
  output logic                         lostsync_s,
  output logic                         evt_valid,
  output gem_event_pkg::evt_op_t       evt_op,
  output logic [`GEM_BX_W-1:0]         evt_bx
);
  import gem_event_pkg::*;

  // ------------------------------
  // monitor to arbiter handshakes
  // ------------------------------
  logic                 mon_req, mon_gnt;
  evt_op_t              mon_op;
  logic                 bc0_req, bc0_gnt;
  evt_op_t              bc0_op;
  logic [`GEM_BX_W-1:0] bx_count;      // shared bx for stamping

  gem_sync_mon u_sync_mon (
    .clock(clock), .arst_n(arst_n), .ttc_resync(ttc_resync),
    .kchar0(kchar0), .kchar1(kchar1), .kchar2(kchar2), .kchar3(kchar3),
    .fiber_enable(fiber_enable), .link_good(link_good),
    .overflow_a(overflow_a), .overflow_b(overflow_b),
    .bc0marker_a(bc0marker_a), .bc0marker_b(bc0marker_b),
    .resyncmarker_a(resyncmarker_a), .resyncmarker_b(resyncmarker_b),
    .gnt(mon_gnt),
    .synced_a(synced_a), .synced_b(synced_b), .synced_s(synced_s),
    .lostsync_a(lostsync_a), .lostsync_b(lostsync_b), .lostsync_s(lostsync_s),
    .req(mon_req), .op(mon_op)
  );

  gem_bc0_check u_bc0_check (
    .clock(clock), .arst_n(arst_n), .ttc_resync(ttc_resync), .ttc_bc0(ttc_bc0),
    .bc0marker_a(bc0marker_a), .bc0marker_b(bc0marker_b),
    .gnt(bc0_gnt),
    .bx_count(bx_count), .req(bc0_req), .op(bc0_op)
  );

  gem_event_arb u_event_arb (
    .clock(clock), .arst_n(arst_n),
    .mon_req(mon_req), .mon_op(mon_op),
    .bc0_req(bc0_req), .bc0_op(bc0_op),
    .bx_count(bx_count), .credit_return(credit_return),
    .mon_gnt(mon_gnt), .bc0_gnt(bc0_gnt),
    .evt_valid(evt_valid), .evt_op(evt_op), .evt_bx(evt_bx)
  );

endmodule

/* gem_sync_clkgen.sv */
`timescale 1ns/100ps

module gem_sync_clkgen (
  output logic clock,
  output logic arst_n
);

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;   // 40 ns period
  end

  // reset held low for three rising edges
  initial begin
    arst_n = 1'b0;
    repeat (3) @(posedge clock);
    #2 arst_n = 1'b1;
  end

endmodule

/* gem_sync_asserts.sv */
`timescale 1ns/100ps
`include "gem_consts.svh"

module gem_sync_asserts (
  input logic       clock,
  input logic       arst_n,
  input logic       mon_req,
  input logic       bc0_req,
  input logic [2:0] mon_op,
  input logic [2:0] bc0_op,
  input logic       mon_gnt,
  input logic       bc0_gnt,
  input logic       credit_return,
  input logic       evt_valid
);

  logic any_gnt;
  int   credits;       // free readout slots rebuilt from grants and returns
  int   fails = 0;     // failed properties so far

  assign any_gnt = mon_gnt | bc0_gnt;

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n)
      credits <= `GEM_EVT_CREDITS;
    else
      credits <= credits - int'(any_gnt) + int'(credit_return);
  end

  // ------------------------------
  // grant rules
  // ------------------------------
  a_one_gnt: assert property (@(posedge clock) disable iff (!arst_n)
    !(mon_gnt && bc0_gnt)) else begin
      fails++;
      $error("both sides granted in one cycle");
    end

  a_credit: assert property (@(posedge clock) disable iff (!arst_n)
    any_gnt |-> (credits > 0)) else begin
      fails++;
      $error("grant with zero credits");
    end

  a_valid: assert property (@(posedge clock) disable iff (!arst_n)
    any_gnt |=> evt_valid) else begin
      fails++;
      $error("no evt_valid after grant");
    end

  // ------------------------------
  // requester holds until granted
  // ------------------------------
  a_mon_hold: assert property (@(posedge clock) disable iff (!arst_n)
    (mon_req && !mon_gnt) |=> (mon_req && $stable(mon_op)))
    else begin
      fails++;
      $error("monitor request dropped or changed before grant");
    end

  a_bc0_hold: assert property (@(posedge clock) disable iff (!arst_n)
    (bc0_req && !bc0_gnt) |=> (bc0_req && $stable(bc0_op)))
    else begin
      fails++;
      $error("bc0 request dropped or changed before grant");
    end

endmodule

bind gem_event_arb gem_sync_asserts u_asserts (
  .clock(clock), .arst_n(arst_n),
  .mon_req(mon_req), .bc0_req(bc0_req), .mon_op(mon_op), .bc0_op(bc0_op),
  .mon_gnt(mon_gnt), .bc0_gnt(bc0_gnt), .credit_return(credit_return),
  .evt_valid(evt_valid)
);

/* gem_sync_tb.sv */
`timescale 1ns/100ps
`include "gem_consts.svh"

module gem_sync_tb;
  import gem_event_pkg::*;

  logic clock, arst_n;
  logic [7:0] kchar0, kchar1, kchar2, kchar3;
  logic [3:0] fiber_enable, link_good;
  logic overflow_a, overflow_b, bc0marker_a, bc0marker_b, resyncmarker_a, resyncmarker_b;
  logic ttc_bc0, ttc_resync, credit_return;
  logic synced_a, synced_b, synced_s, lostsync_a, lostsync_b, lostsync_s, evt_valid;
  evt_op_t evt_op;
  logic [`GEM_BX_W-1:0] evt_bx;

  logic [7:0] cmd, m0, m1, m2, m3, chs;
  logic [8*32-1:0] tname;
  logic [8*128-1:0] line;
  logic [3:0] en4, gd4;
  logic [2:0] es, el;
  logic [1:0] rot;                        // rotation index shared by all fibers
  logic [31:0] lcg_state, credit_lcg;
  logic hold, in_test, done;
  int fd, r, n, c, bx_t, op_i, hv, k;
  int received = 0, returned = 0, cdly = 0;
  int test_err = 0, tests = 0, failed = 0, checks = 0, total_err = 0;
  logic [`GEM_BX_W-1:0] mbx, mbx_d;      // reference bx counter, and one cycle back
  logic [2:0] got_op[$], exp_op[$];
  logic [`GEM_BX_W-1:0] got_bx[$], model_bx[$];

  gem_sync_clkgen u_clkgen (.clock(clock), .arst_n(arst_n));

  gem_sync_top uut (.*);

  // ------------------------------
  // reference model
  // ------------------------------
  function automatic logic [31:0] lcg_next(logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [7:0] sep_at(logic [1:0] i);
    case (i)
      2'd0:    return `GEM_KC_BC;
      2'd1:    return `GEM_KC_F7;
      2'd2:    return `GEM_KC_FB;
      default: return `GEM_KC_FD;
    endcase
  endfunction

  function automatic logic [`GEM_BX_W-1:0] next_bx(logic [`GEM_BX_W-1:0] b, logic bc0);
    if (bc0 || (b == `GEM_BX_W'(`GEM_ORBIT_LEN - 1)))
      return '0;   // orbit start or wrap
    return b + 1'b1;
  endfunction

  always @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      mbx   <= '0;
      mbx_d <= '0;
    end else begin
      mbx   <= next_bx(mbx, ttc_bc0);
      mbx_d <= mbx;                       // bx of the grant cycle
    end
  end

  // readout capture, mid cycle
  always @(negedge clock) begin
    if (arst_n && evt_valid) begin
      got_op.push_back(3'(evt_op));
      got_bx.push_back(evt_bx);
      model_bx.push_back(mbx_d);
      received++;
    end
  end

  // credit returns at lcg spaced intervals
  initial begin
    forever begin
      @(posedge clock);
      #2 credit_return = 1'b0;
      if (cdly > 0)
        cdly--;
      else if (!hold && (returned < received)) begin
        credit_return = 1'b1;
        returned++;
        credit_lcg = lcg_next(credit_lcg);
        cdly = int'(credit_lcg[18:16]);   // 0 to 7 idle cycles
      end
    end
  end

  // ------------------------------
  // stimulus and checks
  // ------------------------------
  // mk bits: ovf a, ovf b, rsm a, rsm b, bc0m a, bc0m b, ttc_bc0, ttc_resync
  task automatic drive_cycle(input logic [7:0] x0, x1, x2, x3, input logic [3:0] en, gd,
                             input logic [7:0] mk);
    @(posedge clock);
    #2;
    kchar0 = sep_at(rot) ^ x0;            // xor mask puts a fiber off rotation
    kchar1 = sep_at(rot) ^ x1;
    kchar2 = sep_at(rot) ^ x2;
    kchar3 = sep_at(rot) ^ x3;
    fiber_enable = en;
    link_good    = gd;
    {ttc_resync, ttc_bc0, bc0marker_b, bc0marker_a} = mk[7:4];
    {resyncmarker_b, resyncmarker_a, overflow_b, overflow_a} = mk[3:0];
    rot = rot + 2'd1;
  endtask

  task automatic clean_cycle();
    drive_cycle(8'h00, 8'h00, 8'h00, 8'h00, 4'hF, 4'hF, 8'h00);
  endtask

  task automatic rand_cycle();
    logic [3:0] mk;
    lcg_state = lcg_next(lcg_state);
    mk = {lcg_state[31:29] == 3'd0, lcg_state[28:26] == 3'd0,
          lcg_state[25:23] == 3'd0, lcg_state[22:20] == 3'd0};   // about one in eight
    drive_cycle(8'h00, 8'h00, 8'h00, 8'h00, 4'hF, 4'hF, {4'h0, mk});
  endtask

  task automatic check_val(input string sig, input int got, input int exp);
    checks++;
    assert (got == exp) else begin
      $display("[FAIL] t=%0t %s got %0h expected %0h", $time, sig, got, exp);
      test_err++;
    end
  endtask

  task automatic marker_at(input logic is_b, input int target);
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < 4000 && !hit; i++) begin
      if (next_bx(mbx, ttc_bc0) == `GEM_BX_W'(target)) begin
        drive_cycle(8'h00, 8'h00, 8'h00, 8'h00, 4'hF, 4'hF, is_b ? 8'h20 : 8'h10);
        hit = 1'b1;
      end else
        clean_cycle();
    end
    assert (hit) else begin
      $display("bx %0d never reached for the bc0 marker", target);
      test_err++;
    end
  endtask

  task automatic wait_events();
    for (int i = 0; i < 300 && got_op.size() < exp_op.size(); i++)
      clean_cycle();
    assert (got_op.size() >= exp_op.size()) else begin
      $display("timed out with %0d of %0d events seen", got_op.size(), exp_op.size());
      test_err++;
    end
    repeat (10) clean_cycle();            // catch late extras
    check_val("event count", got_op.size(), exp_op.size());
    for (int i = 0; i < exp_op.size() && i < got_op.size(); i++) begin
      check_val("evt_op", int'(got_op[i]), int'(exp_op[i]));
      check_val("evt_bx", int'(got_bx[i]), int'(model_bx[i]));
    end
    got_op.delete();
    got_bx.delete();
    model_bx.delete();
    exp_op.delete();
  endtask

  task automatic set_hold(input int v);
    if (v != 0) begin
      for (int i = 0; i < 100 && returned != received; i++)
        clean_cycle();                    // let outstanding credits come home first
      assert (returned == received) else begin
        $display("credits still outstanding before the hold");
        test_err++;
      end
    end
    hold = (v != 0);
  endtask

  task automatic finish_test();
    if (in_test) begin
      tests++;
      if (test_err != 0)
        failed++;
      $display("test %0s: %s, %0d errors", tname, (test_err != 0) ? "FAIL" : "ok", test_err);
      total_err += test_err;
      test_err = 0;
    end
  endtask

  initial begin
    {kchar0, kchar1, kchar2, kchar3} = {4{8'hBC}};
    fiber_enable = 4'hF;
    link_good    = 4'hF;
    {overflow_a, overflow_b, bc0marker_a, bc0marker_b} = 4'b0000;
    {resyncmarker_a, resyncmarker_b, ttc_bc0, ttc_resync, credit_return} = 5'b00000;
    rot        = 2'd0;
    lcg_state  = 32'ha49f2f0d;
    credit_lcg = 32'ha49f2f0d;
    hold    = 1'b0;
    in_test = 1'b0;
    done    = 1'b0;
    tname   = '0;
    fd = $fopen("gem_sync_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open gem_sync_tests.txt");
      total_err++;
    end else begin
      for (k = 0; k < 20 && !arst_n; k++)
        clean_cycle();
      assert (arst_n) else begin
        $display("reset was never released");
        total_err++;
      end
      while (!done) begin
        r = $fscanf(fd, " %s", cmd);
        if (r != 1)
          done = 1'b1;
        else begin
          case (cmd)
            "#": r = $fgets(line, fd);    // comment line
            "T": begin
              finish_test();
              r = $fscanf(fd, " %s", tname);
              in_test = 1'b1;
            end
            "R": begin
              r = $fscanf(fd, " %d", n);
              repeat (n) rand_cycle();
            end
            "X": begin
              r = $fscanf(fd, " %h %h %h %h %h %h", m0, m1, m2, m3, en4, gd4);
              drive_cycle(m0, m1, m2, m3, en4, gd4, 8'h00);
            end
            "Z": drive_cycle(8'h00, 8'h00, 8'h00, 8'h00, 4'hF, 4'hF, 8'h40);
            "Q": drive_cycle(8'h00, 8'h00, 8'h00, 8'h00, 4'hF, 4'hF, 8'h80);
            "P": begin
              r = $fscanf(fd, " %s %d", chs, bx_t);
              marker_at(chs == "b", bx_t);
            end
            "S": begin
              r = $fscanf(fd, " %b %b", es, el);
              check_val("synced_s/b/a", int'({synced_s, synced_b, synced_a}), int'(es));
              check_val("lostsync_s/b/a", int'({lostsync_s, lostsync_b, lostsync_a}), int'(el));
            end
            "V": begin
              r = $fscanf(fd, " %d", op_i);
              exp_op.push_back(3'(op_i));
            end
            "W": wait_events();
            "H": begin
              r = $fscanf(fd, " %d", hv);
              set_hold(hv);
            end
            "N": begin
              r = $fscanf(fd, " %d %d", n, c);
              repeat (c) clean_cycle();
              check_val("events under hold", got_op.size(), n);
            end
            default: begin
              $display("unknown command %s in test file", cmd);
              test_err++;
            end
          endcase
        end
      end
      finish_test();
      $fclose(fd);
    end
    if (uut.u_event_arb.u_asserts.fails != 0) begin
      $display("%0d readout protocol assertions failed", uut.u_event_arb.u_asserts.fails);
      total_err += uut.u_event_arb.u_asserts.fails;
    end
    $display("totals: %0d tests, %0d failed, %0d checks, %0d errors",
             tests, failed, checks, total_err);
    if (total_err == 0 && tests > 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

/* gem_sync_tests.txt */
# T name | R cycles | X mask0 mask1 mask2 mask3 enable good (hex) | Z ttc_bc0 | Q ttc_resync
# P chamber bx | S synced_sba lost_sba | V opcode | W wait events | H hold | N count cycles
T clean_rotation
Q
R 40
S 111 000
W
T chamber_mismatch
Q
R 4
X 00 01 00 00 F F
R 1
S 010 101
R 4
V 1
V 3
W
T bad_separator
Q
R 4
X 00 00 01 00 F F
R 1
S 001 110
R 4
V 2
V 3
W
T masked_faults
Q
R 4
X 00 01 00 00 D F
X 00 00 00 00 D F
R 4
S 111 000
X 00 00 01 00 F B
X 00 00 00 00 F B
R 4
S 111 000
W
T event_order
Q
R 4
X 00 01 01 00 F F
R 4
V 1
V 2
V 3
W
T bc0_alignment
Q
Z
P a 8
R 10
W
P b 100
R 4
V 5
W
T credits
Q
H 1
Z
P a 20
P b 30
X 00 01 00 00 F F
R 4
X 00 00 00 01 F F
R 8
N 4 8
H 0
V 4
V 5
V 1
V 3
V 2
W
T resync
Q
R 4
X 00 01 00 00 F F
R 4
V 1
V 3
W
Q
R 1
S 111 000
R 2
X 00 01 00 00 F F
R 4
V 1
V 3
W

/* build.f */
+incdir+.
gem_link_pkg.sv
gem_event_pkg.sv
gem_sync_mon.sv
gem_bc0_check.sv
gem_event_arb.sv
gem_sync_top.sv
gem_sync_clkgen.sv
gem_sync_asserts.sv
gem_sync_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       := gem_sync_tb
FLIST     := build.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "Test failed" $(LOG); then exit 1; fi
	@grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
